/* src/ex3Pkg.sv */
/*
 EX3 shared definitions
 Micro-op and sub-op codes, load sizes, value source selects,
 the two special register numbers and the extension field union
*/
`default_nettype none

package ex3Pkg;

	// Micro-op codes handled by EX3
	localparam logic [5:0] uCmdNop     = 6'h00;
	localparam logic [5:0] uCmdMovRm   = 6'h04; // Store
	localparam logic [5:0] uCmdMovMr   = 6'h05; // Load
	localparam logic [5:0] uCmdMovIr   = 6'h06;
	localparam logic [5:0] uCmdLeaMr   = 6'h07;
	localparam logic [5:0] uCmdBra     = 6'h08;
	localparam logic [5:0] uCmdJmp     = 6'h0A;
	localparam logic [5:0] uCmdAlu3    = 6'h10;
	localparam logic [5:0] uCmdMul3    = 6'h14;
	localparam logic [5:0] uCmdQmulDiv = 6'h16; // Slow multiply/divide
	localparam logic [5:0] uCmdConvRr  = 6'h18;
	localparam logic [5:0] uCmdOpIxt   = 6'h20; // Sub-op in extension field

	// Key-ring sub-ops
	localparam logic [5:0] ixtLdekrr = 6'h1C; // Load key register
	localparam logic [5:0] ixtLdeenc = 6'h1D; // Encode into DLR

	// Load sizes
	localparam logic [1:0] loadByte  = 2'd0;
	localparam logic [1:0] loadWord  = 2'd1;
	localparam logic [1:0] loadDword = 2'd2;
	localparam logic [1:0] loadQword = 2'd3;

	// Value source for the writeback
	localparam logic [1:0] srcMem = 2'd0;
	localparam logic [1:0] srcMul = 2'd1;
	localparam logic [1:0] srcKrr = 2'd2;

	localparam logic [5:0] gprDlr = 6'd2; // Key-ring encode target
	localparam logic [5:0] crKrr  = 6'd9; // Key register, control bank

	// Load format view of the extension field
	typedef struct packed {
		logic       shift48; // 48-bit value in upper bits
		logic       zeroExt;
		logic       spare;
		logic       ext48;
		logic [1:0] size;
	} ex3LoadFmt;

	// Same six bits, sub-op number or load format
	typedef union packed {
		logic [5:0] ixtOp;
		ex3LoadFmt  loadFmt;
	} ex3Ixt;

endpackage

`default_nettype wire

/* src/ex3CtrlIf.sv */
/*
 EX3 control interface
 Decoded stage control, driven by the decoder and read by the
 execute and result blocks
*/
`timescale 1ns/1ps
`default_nettype none

interface ex3CtrlIf #(
	parameter int RegIdWidth = 7
);
	logic          doMemOp;    // Op touches memory
	logic          doLoad;
	logic [1:0]    outSel;     // Value source
	logic          outDefault; // Value to Rn2 and Rn4
	logic          outHeld;    // Zero to Rn2, value to Rn4
	logic          krrWrite;   // Still needs key-ring ready
	logic          dlrWrite;
	logic          kill;       // Branch flush
	ex3Pkg::ex3Ixt ixt;

	// Special register numbers are six bits wide
	if (RegIdWidth < 6) begin : gIdWidthCheck
		$error("ex3CtrlIf RegIdWidth below 6");
	end

	modport decode (output doMemOp, doLoad, outSel, outDefault, outHeld,
		krrWrite, dlrWrite, kill, ixt);
	modport execute (input doMemOp, doLoad, outSel, ixt);
	modport result (input outSel, outDefault, outHeld, krrWrite, dlrWrite, kill);

endinterface

`default_nettype wire

/* src/ex3Decode.sv */
/*
 EX3 decoder
 Turns the micro-op, its extension field and the branch flush
 into the stage control bits; flags micro-ops EX3 does not know
*/
`timescale 1ns/1ps
`default_nettype none

module ex3Decode #(
	parameter int RegIdWidth = 7
) (
	input  wire logic [5:0]    uCmd,
	input  wire ex3Pkg::ex3Ixt uIxt,
	input  wire logic          braFlush,
	output logic               unhandled,
	ex3CtrlIf.decode           ctrl
);

	logic [5:0] opCmd; // Micro-op after flush

	// DLR and KRR must fit in a register id
	if (RegIdWidth < 6) begin : gIdWidthCheck
		$error("ex3Decode RegIdWidth below 6");
	end

	always_comb begin
		opCmd = braFlush ? ex3Pkg::uCmdNop : uCmd; // Flushed op does nothing

		ctrl.doMemOp    = 1'b0;
		ctrl.doLoad     = 1'b0;
		ctrl.outSel     = ex3Pkg::srcMem;
		ctrl.outDefault = 1'b0;
		ctrl.outHeld    = 1'b0;
		ctrl.krrWrite   = 1'b0;
		ctrl.dlrWrite   = 1'b0;
		ctrl.kill       = braFlush;
		ctrl.ixt        = uIxt;
		unhandled       = 1'b0;

		case (opCmd)
			ex3Pkg::uCmdNop: begin
			end
			ex3Pkg::uCmdOpIxt: begin
				// Only the key-ring sub-ops finish here
				case (uIxt.ixtOp)
					ex3Pkg::ixtLdekrr: begin
						ctrl.outSel   = ex3Pkg::srcKrr;
						ctrl.krrWrite = 1'b1; // Checked against status later
					end
					ex3Pkg::ixtLdeenc: begin
						ctrl.outSel   = ex3Pkg::srcKrr;
						ctrl.dlrWrite = 1'b1;
					end
					default: begin
					end
				endcase
			end
			ex3Pkg::uCmdMovRm: ctrl.doMemOp = 1'b1; // Store, nothing to write back
			ex3Pkg::uCmdMovMr: begin
				ctrl.doMemOp    = 1'b1;
				ctrl.doLoad     = 1'b1;
				ctrl.outDefault = 1'b1; // Loaded word to Rm
			end
			ex3Pkg::uCmdMul3: begin
				ctrl.outSel  = ex3Pkg::srcMul;
				ctrl.outHeld = 1'b1; // Product only on the late port
			end
			ex3Pkg::uCmdQmulDiv: begin
				ctrl.outSel     = ex3Pkg::srcMul;
				ctrl.outDefault = 1'b1; // Result gates on mulDone
			end
			ex3Pkg::uCmdAlu3, ex3Pkg::uCmdBra, ex3Pkg::uCmdJmp,
			ex3Pkg::uCmdMovIr, ex3Pkg::uCmdLeaMr, ex3Pkg::uCmdConvRr: begin
				// Done in earlier stages
			end
			default: unhandled = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

/* src/ex3Execute.sv */
/*
 EX3 execute
 Formats loaded data, picks the writeback value from memory,
 multiplier or key ring, and evaluates the memory status
*/
`timescale 1ns/1ps
`default_nettype none

module ex3Execute (
	input  wire logic [63:0] memData,
	input  wire logic [1:0]  memStatus,
	input  wire logic [63:0] mulResult,
	input  wire logic [65:0] krreResult, // Status in top two bits
	output logic      [63:0] exValue,
	output logic             krrOk,
	output logic             memStall,
	output logic             memFault,
	ex3CtrlIf.execute        ctrl
);

	ex3Pkg::ex3LoadFmt fmt;
	logic [63:0]       loadValue; // Formatted load word
	logic              signFill;

	assign fmt = ctrl.ixt.loadFmt;

	always_comb begin
		signFill = 1'b0;
		if (fmt.ext48) begin
			signFill = memData[47] & ~fmt.zeroExt;
			if (fmt.shift48)
				loadValue = {memData[47:0], 16'h0000}; // Upper placement
			else
				loadValue = {{16{signFill}}, memData[47:0]};
		end else begin
			case (fmt.size)
				ex3Pkg::loadByte: begin
					signFill  = memData[7] & ~fmt.zeroExt;
					loadValue = {{56{signFill}}, memData[7:0]};
				end
				ex3Pkg::loadWord: begin
					signFill  = memData[15] & ~fmt.zeroExt;
					loadValue = {{48{signFill}}, memData[15:0]};
				end
				ex3Pkg::loadDword: begin
					signFill  = memData[31] & ~fmt.zeroExt;
					loadValue = {{32{signFill}}, memData[31:0]};
				end
				default: loadValue = memData; // Qword as is
			endcase
		end
	end

	always_comb begin
		case (ctrl.outSel)
			// Memory source only carries data on a load
			ex3Pkg::srcMem: exValue = ctrl.doLoad ? loadValue : 64'd0;
			ex3Pkg::srcMul: exValue = mulResult;
			ex3Pkg::srcKrr: exValue = krreResult[63:0];
			default:        exValue = 64'd0;
		endcase
	end

	assign krrOk = (krreResult[65:64] == 2'b10); // Key ring ready

	// Status 10 waits, 11 faults
	assign memStall = ctrl.doMemOp && (memStatus == 2'b10);
	assign memFault = ctrl.doMemOp && (memStatus == 2'b11);

endmodule

`default_nettype wire

/* src/ex3Result.sv */
/*
 EX3 result
 Builds the Rn2, Cn2 and Rn4 destinations from the forwarded EX1
 values and the op, cancels them on flush and registers them
 under pipeline hold; drives the hold bits back upstream
*/
`timescale 1ns/1ps
`default_nettype none

module ex3Result #(
	parameter int RegIdWidth = 7
) (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  exIsHold,
	input  wire logic                  mulDone,
	input  wire logic [RegIdWidth-1:0] idRn1,
	input  wire logic [63:0]           valRn1,
	input  wire logic [RegIdWidth-1:0] idCn1,
	input  wire logic [63:0]           valCn1,
	input  wire logic [RegIdWidth-1:0] idRm,
	input  wire logic [63:0]           exValue,
	input  wire logic                  krrOk,
	input  wire logic                  memStall,
	input  wire logic                  memFault,
	input  wire logic                  unhandled,
	output logic      [RegIdWidth-1:0] idRn2,
	output logic      [63:0]           valRn2,
	output logic      [RegIdWidth-1:0] idCn2,
	output logic      [63:0]           valCn2,
	output logic      [RegIdWidth-1:0] idRn4,
	output logic      [63:0]           valRn4,
	output logic      [1:0]            exHold,
	output logic                       faultPulse,
	output logic                       unhandledPulse,
	ex3CtrlIf.result                   ctrl
);

	localparam logic [RegIdWidth-1:0] zzrId = '1; // Zero register

	logic [RegIdWidth-1:0] nxtIdRn2, nxtIdCn2, nxtIdRn4;
	logic [63:0]           nxtValRn2, nxtValCn2, nxtValRn4;
	logic                  dflOk;

	// Slow op only writes once the multiplier is done
	assign dflOk = ctrl.outDefault && (ctrl.outSel != ex3Pkg::srcMul || mulDone);

	always_comb begin
		nxtIdRn2  = idRn1; // Forward by default
		nxtValRn2 = valRn1;
		nxtIdCn2  = idCn1;
		nxtValCn2 = valCn1;
		nxtIdRn4  = idRn1;
		nxtValRn4 = valRn1;
		if (ctrl.outHeld) begin
			nxtIdRn2  = idRm;
			nxtValRn2 = 64'd0; // Real value arrives late
			nxtIdRn4  = idRm;
			nxtValRn4 = exValue;
		end
		if (dflOk) begin
			nxtIdRn2  = idRm;
			nxtValRn2 = exValue;
			nxtIdRn4  = idRm;
			nxtValRn4 = exValue;
		end
		if (ctrl.dlrWrite) begin
			nxtIdRn2  = RegIdWidth'(ex3Pkg::gprDlr);
			nxtValRn2 = exValue;
		end
		if (ctrl.krrWrite && krrOk) begin
			nxtIdCn2  = RegIdWidth'(ex3Pkg::crKrr);
			nxtValCn2 = exValue;
		end
		if (ctrl.kill) begin
			// Flushed op writes nothing
			nxtIdRn2 = zzrId;
			nxtIdCn2 = zzrId;
			nxtIdRn4 = zzrId;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			idRn2          <= zzrId;
			valRn2         <= 64'd0;
			idCn2          <= zzrId;
			valCn2         <= 64'd0;
			idRn4          <= zzrId;
			valRn4         <= 64'd0;
			faultPulse     <= 1'b0;
			unhandledPulse <= 1'b0;
		end else if (exIsHold) begin
			faultPulse     <= 1'b0; // Contents kept, pulses drop
			unhandledPulse <= 1'b0;
		end else begin
			idRn2          <= nxtIdRn2;
			valRn2         <= nxtValRn2;
			idCn2          <= nxtIdCn2;
			valCn2         <= nxtValCn2;
			idRn4          <= nxtIdRn4;
			valRn4         <= nxtValRn4;
			faultPulse     <= memFault;
			unhandledPulse <= unhandled;
		end
	end

	assign exHold = {ctrl.outHeld && !ctrl.kill, memStall}; // Held result, mem stall

endmodule

`default_nettype wire

/* src/ex3Stage.sv */
/*
 EX3 stage top
 Third execute stage of one lane; decode, execute and result
 blocks joined by the control interface
*/
`timescale 1ns/1ps
`default_nettype none

module ex3Stage #(
	parameter int RegIdWidth = 7
) (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic [5:0]            uCmd,
	input  wire ex3Pkg::ex3Ixt         uIxt,
	input  wire logic                  braFlush,
	input  wire logic                  exIsHold,
	input  wire logic [RegIdWidth-1:0] idRn1,
	input  wire logic [63:0]           valRn1,
	input  wire logic [RegIdWidth-1:0] idCn1,
	input  wire logic [63:0]           valCn1,
	input  wire logic [RegIdWidth-1:0] idRm,
	input  wire logic [63:0]           memData,
	input  wire logic [1:0]            memStatus,
	input  wire logic [63:0]           mulResult,
	input  wire logic                  mulDone,
	input  wire logic [65:0]           krreResult,
	output logic      [RegIdWidth-1:0] idRn2,
	output logic      [63:0]           valRn2,
	output logic      [RegIdWidth-1:0] idCn2,
	output logic      [63:0]           valCn2,
	output logic      [RegIdWidth-1:0] idRn4,
	output logic      [63:0]           valRn4,
	output logic      [1:0]            exHold,
	output logic                       memFault,
	output logic                       unhandledOp
);

	logic [63:0] exValue;
	logic        krrOk;
	logic        memStall;
	logic        memFaultNow; // Before the output register
	logic        unhandledNow;

	ex3CtrlIf #(.RegIdWidth(RegIdWidth)) ctrl ();

	ex3Decode #(.RegIdWidth(RegIdWidth)) decode_i (
		.uCmd(uCmd), .uIxt(uIxt), .braFlush(braFlush),
		.unhandled(unhandledNow), .ctrl(ctrl.decode)
	);

	ex3Execute execute_i (
		.memData(memData), .memStatus(memStatus), .mulResult(mulResult),
		.krreResult(krreResult), .exValue(exValue), .krrOk(krrOk),
		.memStall(memStall), .memFault(memFaultNow), .ctrl(ctrl.execute)
	);

	ex3Result #(.RegIdWidth(RegIdWidth)) result_i (
		.clock(clock), .reset(reset), .exIsHold(exIsHold), .mulDone(mulDone),
		.idRn1(idRn1), .valRn1(valRn1), .idCn1(idCn1), .valCn1(valCn1),
		.idRm(idRm), .exValue(exValue), .krrOk(krrOk), .memStall(memStall),
		.memFault(memFaultNow), .unhandled(unhandledNow),
		.idRn2(idRn2), .valRn2(valRn2), .idCn2(idCn2), .valCn2(valCn2),
		.idRn4(idRn4), .valRn4(valRn4), .exHold(exHold),
		.faultPulse(memFault), .unhandledPulse(unhandledOp), .ctrl(ctrl.result)
	);

endmodule

`default_nettype wire

/* verif/ex3Stage_assertions.sv */
/*
 EX3 result checks
 Hold freezes the outputs, a flush leaves only ZZR ids,
 and a held multiply shows zero on Rn2
*/
`timescale 1ns/1ps
`default_nettype none

module ex3StageAssertions #(
	parameter int RegIdWidth = 7
) (
	input wire logic                  clock,
	input wire logic                  reset,
	input wire logic                  exIsHold,
	input wire logic                  kill,
	input wire logic [1:0]            exHold,
	input wire logic [RegIdWidth-1:0] idRn2,
	input wire logic [63:0]           valRn2,
	input wire logic [RegIdWidth-1:0] idCn2,
	input wire logic [63:0]           valCn2,
	input wire logic [RegIdWidth-1:0] idRn4,
	input wire logic [63:0]           valRn4
);

	localparam logic [RegIdWidth-1:0] zzrId = '1;

	int failures = 0; // Failed assertion count

	holdFreezes: assert property (@(posedge clock) disable iff (reset)
		exIsHold |=> $stable(idRn2) && $stable(valRn2) && $stable(idCn2)
			&& $stable(valCn2) && $stable(idRn4) && $stable(valRn4))
		else begin
			$error("outputs changed while exIsHold was high");
			failures++;
		end

	// Flushed op registers ZZR everywhere
	killClearsIds: assert property (@(posedge clock) disable iff (reset)
		kill && !exIsHold |=> idRn2 == zzrId && idCn2 == zzrId && idRn4 == zzrId)
		else begin
			$error("id other than ZZR after a flush");
			failures++;
		end

	heldZeroRn2: assert property (@(posedge clock) disable iff (reset)
		exHold[1] && !exIsHold |=> valRn2 == 64'd0)
		else begin
			$error("valRn2 not zero after a held result");
			failures++;
		end

endmodule

bind ex3Result ex3StageAssertions #(.RegIdWidth(RegIdWidth)) assertions_i (
	.clock(clock), .reset(reset), .exIsHold(exIsHold), .kill(ctrl.kill),
	.exHold(exHold), .idRn2(idRn2), .valRn2(valRn2), .idCn2(idCn2),
	.valCn2(valCn2), .idRn4(idRn4), .valRn4(valRn4)
);

`default_nettype wire

/* verif/ex3StageTb.sv */
/*
 EX3 stage testbench
 Directed tests for forwarding, load formats, multiply routing,
 key ring writes, flush, pipeline hold and memory status
*/
`timescale 1ns/1ps
`default_nettype none

module ex3StageTb;

	localparam int IdW = 7;
	localparam logic [IdW-1:0] zzr = '1; // Zero register id

	logic           clock;
	logic           reset;
	logic [5:0]     uCmd;
	ex3Pkg::ex3Ixt  uIxt;
	logic           braFlush;
	logic           exIsHold;
	logic [IdW-1:0] idRn1, idCn1, idRm;
	logic [63:0]    valRn1, valCn1, memData, mulResult;
	logic [1:0]     memStatus;
	logic           mulDone;
	logic [65:0]    krreResult; // Status in bits 65:64
	logic [IdW-1:0] idRn2, idCn2, idRn4;
	logic [63:0]    valRn2, valCn2, valRn4;
	logic [1:0]     exHold;
	logic           memFault, unhandledOp;
	integer         seed;
	int             valueErrors, otherErrors, assertErrors;

	ex3Stage #(.RegIdWidth(IdW)) dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	// Expected load word for a given format field
	function automatic logic [63:0] formattedLoad(input logic [63:0] d, input logic [5:0] fmtBits);
		logic [1:0] size;
		logic       zx;
		size = fmtBits[1:0];
		zx   = fmtBits[4];
		if (fmtBits[2] && fmtBits[5])
			return {d[47:0], 16'h0000}; // Shifted 48-bit
		if (fmtBits[2])
			return zx ? {16'h0000, d[47:0]} : 64'($signed(d[47:0]));
		case (size)
			ex3Pkg::loadByte:  return zx ? 64'(d[7:0]) : 64'($signed(d[7:0]));
			ex3Pkg::loadWord:  return zx ? 64'(d[15:0]) : 64'($signed(d[15:0]));
			ex3Pkg::loadDword: return zx ? 64'(d[31:0]) : 64'($signed(d[31:0]));
			default:           return d;
		endcase
	endfunction

	task automatic destCheck(input string port, input logic [IdW-1:0] gotId,
		input logic [IdW-1:0] expId, input logic [63:0] gotVal, input logic [63:0] expVal);
		if (gotId !== expId) begin
			$display("error id%s: got 0x%h expected 0x%h", port, gotId, expId);
			valueErrors++;
		end
		if (gotVal !== expVal) begin
			$display("error val%s: got 0x%h expected 0x%h", port, gotVal, expVal);
			valueErrors++;
		end
	endtask

	task automatic crDestCheck(input logic [IdW-1:0] gotId, input logic [IdW-1:0] expId,
		input logic [63:0] gotVal, input logic [63:0] expVal);
		if (gotId !== expId) begin
			$display("error idCn2: got 0x%h expected 0x%h", gotId, expId);
			valueErrors++;
		end
		if (gotVal !== expVal) begin
			$display("error valCn2: got 0x%h expected 0x%h", gotVal, expVal);
			valueErrors++;
		end
	endtask

	task automatic holdCheck(input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("error exHold: got 0x%h expected 0x%h", got, exp);
			valueErrors++;
		end
	endtask

	task automatic pulseCheck(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic newOperands();
		idRn1      <= IdW'($random(seed));
		valRn1     <= {$random(seed), $random(seed)};
		idCn1      <= IdW'($random(seed));
		valCn1     <= {$random(seed), $random(seed)};
		idRm       <= IdW'($random(seed));
		memData    <= {$random(seed), $random(seed)};
		mulResult  <= {$random(seed), $random(seed)};
		krreResult <= {2'b00, $random(seed), $random(seed)}; // Not ready
	endtask

	task automatic idleInputs();
		uCmd       <= ex3Pkg::uCmdNop;
		uIxt.ixtOp <= 6'd0;
		braFlush   <= 1'b0;
		exIsHold   <= 1'b0;
		memStatus  <= 2'b00;
		mulDone    <= 1'b0;
	endtask

	// New op with fresh operands on the next rising edge
	task automatic issue(input logic [5:0] cmd, input logic [5:0] ixtBits);
		@(posedge clock);
		newOperands();
		uCmd       <= cmd;
		uIxt.ixtOp <= ixtBits;
	endtask

	// Op sees one edge, then the inputs go idle; sample mid-cycle
	task automatic retire();
		@(posedge clock);
		idleInputs();
		@(negedge clock);
	endtask

	task automatic resetAndForward();
		destCheck("Rn2", idRn2, zzr, valRn2, 64'd0); // Still the reset state
		crDestCheck(idCn2, zzr, valCn2, 64'd0);
		destCheck("Rn4", idRn4, zzr, valRn4, 64'd0);
		pulseCheck("memFault", memFault, 1'b0);
		pulseCheck("unhandledOp", unhandledOp, 1'b0);
		issue(ex3Pkg::uCmdNop, 6'd0);
		@(negedge clock);
		retire();
		destCheck("Rn2", idRn2, idRn1, valRn2, valRn1);
		crDestCheck(idCn2, idCn1, valCn2, valCn1);
		destCheck("Rn4", idRn4, idRn1, valRn4, valRn1);
	endtask

	task automatic loadFormats();
		logic [5:0]  fmtBits;
		logic [63:0] expVal;
		for (int i = 0; i < 16; i++) begin
			// Shift48 only matters with ext48
			fmtBits = {i[3] & i[0], i[2], 1'b0, i[3], i[1:0]};
			issue(ex3Pkg::uCmdMovMr, fmtBits);
			@(negedge clock);
			expVal = formattedLoad(memData, fmtBits);
			retire();
			destCheck("Rn2", idRn2, idRm, valRn2, expVal);
			destCheck("Rn4", idRn4, idRm, valRn4, expVal);
		end
	endtask

	task automatic multiplyRouting();
		issue(ex3Pkg::uCmdMul3, 6'd0);
		@(negedge clock);
		holdCheck(exHold, 2'b10); // Held result in flight
		retire();
		destCheck("Rn2", idRn2, idRm, valRn2, 64'd0);
		destCheck("Rn4", idRn4, idRm, valRn4, mulResult);
		for (int done = 0; done < 2; done++) begin
			issue(ex3Pkg::uCmdQmulDiv, 6'd0);
			mulDone <= done[0];
			@(negedge clock);
			holdCheck(exHold, 2'b00);
			retire();
			if (done[0]) begin
				destCheck("Rn2", idRn2, idRm, valRn2, mulResult);
				destCheck("Rn4", idRn4, idRm, valRn4, mulResult);
			end else begin
				destCheck("Rn2", idRn2, idRn1, valRn2, valRn1); // Not done yet
				destCheck("Rn4", idRn4, idRn1, valRn4, valRn1);
			end
		end
	endtask

	task automatic keyRingWrites();
		issue(ex3Pkg::uCmdOpIxt, ex3Pkg::ixtLdeenc);
		@(negedge clock);
		retire();
		destCheck("Rn2", idRn2, IdW'(ex3Pkg::gprDlr), valRn2, krreResult[63:0]);
		destCheck("Rn4", idRn4, idRn1, valRn4, valRn1);
		for (int st = 0; st < 4; st++) begin
			issue(ex3Pkg::uCmdOpIxt, ex3Pkg::ixtLdekrr);
			krreResult[65:64] <= st[1:0];
			@(negedge clock);
			retire();
			if (st == 2)
				crDestCheck(idCn2, IdW'(ex3Pkg::crKrr), valCn2, krreResult[63:0]);
			else
				crDestCheck(idCn2, idCn1, valCn2, valCn1); // Key ring not ready
			destCheck("Rn2", idRn2, idRn1, valRn2, valRn1);
		end
	endtask

	task automatic flushAndHold();
		logic [IdW-1:0] frozenIdRn2, frozenIdRn4;
		logic [63:0]    frozenValRn2, frozenValRn4;
		int             edges;
		issue(ex3Pkg::uCmdMovMr, 6'd3);
		braFlush <= 1'b1;
		@(negedge clock);
		retire();
		destCheck("Rn2", idRn2, zzr, valRn2, valRn1); // Flushed load is a NOP
		crDestCheck(idCn2, zzr, valCn2, valCn1);
		destCheck("Rn4", idRn4, zzr, valRn4, valRn1);
		issue(ex3Pkg::uCmdMul3, 6'd0); // Waits behind the hold
		exIsHold <= 1'b1;
		@(negedge clock);
		frozenIdRn2  = idRn2;
		frozenValRn2 = valRn2;
		frozenIdRn4  = idRn4;
		frozenValRn4 = valRn4;
		repeat (3) begin
			@(posedge clock);
			@(negedge clock);
			destCheck("Rn2", idRn2, frozenIdRn2, valRn2, frozenValRn2);
			destCheck("Rn4", idRn4, frozenIdRn4, valRn4, frozenValRn4);
		end
		@(posedge clock);
		exIsHold <= 1'b0;
		edges = 0;
		do begin
			@(posedge clock);
			idleInputs();
			@(negedge clock);
			edges++;
		end while (valRn4 !== mulResult && edges < 4);
		if (edges != 1) begin
			$display("hold release: result showed up after %0d edges instead of one", edges);
			otherErrors++;
		end
		destCheck("Rn4", idRn4, idRm, valRn4, mulResult);
	endtask

	task automatic memStatusAndUnknown();
		issue(ex3Pkg::uCmdMovMr, 6'd3);
		memStatus <= 2'b10;
		@(negedge clock);
		holdCheck(exHold, 2'b01); // Stall in the same cycle
		retire();
		pulseCheck("memFault", memFault, 1'b0);
		issue(ex3Pkg::uCmdMovMr, 6'd3);
		memStatus <= 2'b11;
		@(negedge clock);
		holdCheck(exHold, 2'b00); // Fault, no stall
		retire();
		pulseCheck("memFault", memFault, 1'b1);
		retire();
		pulseCheck("memFault", memFault, 1'b0);
		issue(6'h3F, 6'd0); // Not a listed micro-op
		@(negedge clock);
		retire();
		pulseCheck("unhandledOp", unhandledOp, 1'b1);
		retire();
		pulseCheck("unhandledOp", unhandledOp, 1'b0);
	endtask

	initial begin
		seed         = 32'h5be0f14b;
		valueErrors  = 0;
		otherErrors  = 0;
		assertErrors = 0;
		reset        <= 1'b1;
		idleInputs();
		newOperands();
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		resetAndForward();
		loadFormats();
		multiplyRouting();
		keyRingWrites();
		flushAndHold();
		memStatusAndUnknown();
		assertErrors = dut_i.result_i.assertions_i.failures;
		$display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			valueErrors, otherErrors, assertErrors);
		if (valueErrors + otherErrors + assertErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog in case the run gets stuck
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < 5000) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: tests did not finish within 5000 cycles");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
src/ex3Pkg.sv
src/ex3CtrlIf.sv
src/ex3Decode.sv
src/ex3Execute.sv
src/ex3Result.sv
src/ex3Stage.sv
verif/ex3Stage_assertions.sv
verif/ex3StageTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ex3StageTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test: FAIL"; exit 1; \
	else \
		echo "test: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
